//--- hdl/cpu8Pkg.sv
`default_nettype none

package cpu8Pkg;

    //******************************************************************
    // Opcodes, 4-bit field in the low nibble of every instruction
    //******************************************************************
    localparam logic [3:0] opNop  = 4'h0;
    localparam logic [3:0] opLdi  = 4'h1;   // rd <= imm
    localparam logic [3:0] opAdd  = 4'h2;
    localparam logic [3:0] opSub  = 4'h3;
    localparam logic [3:0] opAnd  = 4'h4;
    localparam logic [3:0] opOr   = 4'h5;
    localparam logic [3:0] opXor  = 4'h6;
    localparam logic [3:0] opAdc  = 4'h7;   // Add with carry flag
    localparam logic [3:0] opSt   = 4'h8;   // mem[rs] <= rd
    localparam logic [3:0] opLd   = 4'h9;   // rd <= mem[rs]
    localparam logic [3:0] opOut  = 4'hA;
    localparam logic [3:0] opOutf = 4'hB;   // Output the status word
    localparam logic [3:0] opJz   = 4'hC;
    localparam logic [3:0] opHalt = 4'hD;

    // Status word bit positions, bit 3 unused
    localparam int flagC = 0;
    localparam int flagZ = 1;
    localparam int flagN = 2;

    //******************************************************************
    // Instruction word layouts
    //******************************************************************
    typedef struct packed {
        logic [3:0] rd;     // [15:12]
        logic [7:0] imm;    // [11:4]
        logic [3:0] op;     // [3:0]
    } immFieldsT;

    typedef struct packed {
        logic [3:0] rd;     // [15:12]
        logic [3:0] rs;     // [11:8]
        logic [3:0] spare;
        logic [3:0] op;     // Same place as in immFieldsT
    } regFieldsT;

    // One word, two views
    typedef union packed {
        immFieldsT immF;
        regFieldsT regF;
    } instrWordT;

endpackage

`default_nettype wire

//--- hdl/cpu8If.sv
`timescale 1ns/10ps
`default_nettype none

//**********************************************************************
// Fetch side, program counter and instruction word
//**********************************************************************
interface fetchIf import cpu8Pkg::*; ();
    instrWordT  instr;          // Registered imem output
    logic [7:0] pc;
    logic       fetchEn;        // Read at pc, then pc+1
    logic       jumpEn;
    logic [7:0] jumpTarget;
    logic       pcClear;        // Level, holds pc at 0

    modport fetch (output instr, pc,
                   input  fetchEn, jumpEn, jumpTarget, pcClear);
    modport core  (input  instr, pc,
                   output fetchEn, jumpEn, jumpTarget, pcClear);
endinterface

//**********************************************************************
// Data side, RAM access and output port
//**********************************************************************
interface dataIf #(
    parameter int dataAddrWidth = 8
) ();
    logic [dataAddrWidth-1:0] addr;
    logic [7:0]               wrData;   // RAM write data or output value
    logic                     wrEn;
    logic                     rdEn;
    logic                     outEn;    // Load output register
    logic [7:0]               rdData;   // Valid the cycle after rdEn

    modport core (output addr, wrData, wrEn, rdEn, outEn,
                  input  rdData);
    modport port (input  addr, wrData, wrEn, rdEn, outEn,
                  output rdData);
endinterface

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpu8Pkg::*; (
    input  logic [7:0] dataA,
    input  logic [7:0] dataB,
    input  logic [3:0] mode,      // Opcode of the current instruction
    input  logic       cin,       // Carry flag, ADC only
    output logic [7:0] result,
    output logic       cout,
    output logic       zout,
    output logic       nout
);

    logic [8:0] sum;              // 9 bits, carry in the top bit

    always_comb begin
        sum    = 9'd0;
        result = dataB;           // Pass-through, used by LDI
        cout   = 1'b0;
        case (mode)
            opAdd: begin
                sum    = {1'b0, dataA} + {1'b0, dataB};
                result = sum[7:0];
                cout   = sum[8];
            end
            opAdc: begin
                sum    = {1'b0, dataA} + {1'b0, dataB} + {8'd0, cin};
                result = sum[7:0];
                cout   = sum[8];
            end
            opSub: begin
                result = dataA - dataB;           // Mod 256
                cout   = (dataA < dataB);         // Borrow
            end
            opAnd: result = dataA & dataB;
            opOr:  result = dataA | dataB;
            opXor: result = dataA ^ dataB;
            default: ;
        endcase
    end

    // Flags from the result
    assign zout = (result == 8'd0);
    assign nout = result[7];

endmodule

`default_nettype wire

//--- hdl/fetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import cpu8Pkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        progWrEn,
    input  logic [7:0]  progAddr,
    input  logic [15:0] progData,
    fetchIf.fetch       fch
);

    //******************************************************************
    // Instruction memory, 256 words
    //******************************************************************
    instrWordT imem [0:255];

    // Program load port, only used while the core is idle
    always_ff @(posedge clk) begin
        if (progWrEn) begin
            imem[progAddr] <= progData;
        end
    end

    // Synchronous read, one cycle latency
    always_ff @(posedge clk) begin
        if (fch.fetchEn) begin
            fch.instr <= imem[fch.pc];
        end
    end

    //******************************************************************
    // Program counter
    //******************************************************************
    // Clear wins over jump, jump over fetch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fch.pc <= 8'd0;
        end else if (fch.pcClear) begin
            fch.pc <= 8'd0;
        end else if (fch.jumpEn) begin
            fch.pc <= fch.jumpTarget;          // Absolute target
        end else if (fch.fetchEn) begin
            fch.pc <= fch.pc + 8'd1;           // Wraps at 255
        end
    end

endmodule

`default_nettype wire

//--- hdl/execCore.sv
`timescale 1ns/10ps
`default_nettype none

module execCore import cpu8Pkg::*; #(
    parameter int dataAddrWidth = 8
) (
    input  logic clk,
    input  logic rstN,
    input  logic run,
    output logic halted,
    fetchIf.core fch,
    dataIf.core  dat
);

    //******************************************************************
    // Control FSM
    //******************************************************************
    localparam logic [2:0] sIdle   = 3'd0;
    localparam logic [2:0] sFetch  = 3'd1;
    localparam logic [2:0] sExec   = 3'd2;
    localparam logic [2:0] sLdWait = 3'd3;  // RAM read returns
    localparam logic [2:0] sHalt   = 3'd4;

    logic [2:0] state;
    logic [3:0] op;

    assign op = fch.instr.immF.op;          // Same in both views

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
        end else if (!run) begin
            state <= sIdle;                 // Dropping run always stops
        end else begin
            case (state)
                sIdle:   state <= sFetch;
                sFetch:  state <= sExec;
                sExec: begin
                    if (op == opLd) begin
                        state <= sLdWait;
                    end else if (op == opHalt) begin
                        state <= sHalt;
                    end else begin
                        state <= sFetch;
                    end
                end
                sLdWait: state <= sFetch;
                sHalt:   state <= sHalt;    // Until run drops
                default: state <= sIdle;
            endcase
        end
    end

    //******************************************************************
    // Decode
    //******************************************************************
    logic       exec;
    logic       isAlu;
    logic [7:0] immVal;
    logic [3:0] rdSel;
    logic [3:0] rsSel;

    assign exec   = (state == sExec);
    assign immVal = fch.instr.immF.imm;
    assign rdSel  = fch.instr.regF.rd;
    assign rsSel  = fch.instr.regF.rs;

    always_comb begin
        case (op)
            opAdd, opSub, opAnd, opOr, opXor, opAdc: isAlu = 1'b1;
            default:                                 isAlu = 1'b0;
        endcase
    end

    //******************************************************************
    // Register file and status flags
    //******************************************************************
    logic [7:0] regs [0:15];
    logic [3:0] status;                     // {0, N, Z, C}
    logic [7:0] rdVal;
    logic [7:0] rsVal;
    logic [7:0] aluB;
    logic [7:0] aluResult;
    logic       aluC;
    logic       aluZ;
    logic       aluN;
    logic       regWe;
    logic [7:0] regWrData;

    assign rdVal = regs[rdSel];
    assign rsVal = regs[rsSel];

    // Operand B, register or immediate
    assign aluB = (op == opLdi) ? immVal : rsVal;

    // Write-back source, ALU or RAM
    assign regWe     = (exec && (isAlu || op == opLdi)) || (state == sLdWait);
    assign regWrData = (state == sLdWait) ? dat.rdData : aluResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (regWe) begin
            regs[rdSel] <= regWrData;
        end
    end

    // Flags only move on ALU ops
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            status <= 4'd0;
        end else if (exec && isAlu) begin
            status[flagC] <= aluC;
            status[flagZ] <= aluZ;
            status[flagN] <= aluN;
        end
    end

    alu alu_i (
        .dataA  (rdVal),
        .dataB  (aluB),
        .mode   (op),
        .cin    (status[flagC]),
        .result (aluResult),
        .cout   (aluC),
        .zout   (aluZ),
        .nout   (aluN)
    );

    //******************************************************************
    // Fetch and data side controls
    //******************************************************************
    assign fch.pcClear    = (state == sIdle);
    assign fch.fetchEn    = (state == sFetch);
    assign fch.jumpEn     = exec && (op == opJz) && status[flagZ];
    assign fch.jumpTarget = immVal;

    assign dat.addr   = rsVal[dataAddrWidth-1:0];   // Low address bits
    assign dat.wrData = (op == opOutf) ? {4'd0, status} : rdVal;
    assign dat.wrEn   = exec && (op == opSt);
    assign dat.rdEn   = exec && (op == opLd);
    assign dat.outEn  = exec && (op == opOut || op == opOutf);

    assign halted = (state == sHalt);

endmodule

`default_nettype wire

//--- hdl/dataPort.sv
`timescale 1ns/10ps
`default_nettype none

module dataPort #(
    parameter int dataAddrWidth = 8
) (
    input  logic       clk,
    input  logic       rstN,
    output logic [7:0] outData,
    output logic       outStrobe,
    dataIf.port        dat
);

    //******************************************************************
    // Data RAM
    //******************************************************************
    logic [7:0] ram [0:(1<<dataAddrWidth)-1];

    always_ff @(posedge clk) begin
        if (dat.wrEn) begin
            ram[dat.addr] <= dat.wrData;
        end
        if (dat.rdEn) begin
            dat.rdData <= ram[dat.addr];    // Ready next cycle
        end
    end

    //******************************************************************
    // Output register and strobe
    //******************************************************************
    // Value held until the next OUT
    always_ff @(posedge clk) begin
        if (dat.outEn) begin
            outData <= dat.wrData;
        end
    end

    // High for one cycle, aligned with new outData
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= dat.outEn;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu8Top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu8Top #(
    parameter int dataAddrWidth = 8         // 4 to 8
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        run,
    input  logic        progWrEn,
    input  logic [7:0]  progAddr,
    input  logic [15:0] progData,
    output logic [7:0]  outData,
    output logic        outStrobe,
    output logic        halted
);

    fetchIf fchBus ();
    dataIf #(.dataAddrWidth(dataAddrWidth)) datBus ();

    // Input side, pc and instruction memory
    fetchUnit fetchUnit_i (
        .clk      (clk),
        .rstN     (rstN),
        .progWrEn (progWrEn),
        .progAddr (progAddr),
        .progData (progData),
        .fch      (fchBus.fetch)
    );

    // FSM, registers, flags, ALU
    execCore #(.dataAddrWidth(dataAddrWidth)) execCore_i (
        .clk    (clk),
        .rstN   (rstN),
        .run    (run),
        .halted (halted),
        .fch    (fchBus.core),
        .dat    (datBus.core)
    );

    // Output side, data RAM and output register
    dataPort #(.dataAddrWidth(dataAddrWidth)) dataPort_i (
        .clk       (clk),
        .rstN      (rstN),
        .outData   (outData),
        .outStrobe (outStrobe),
        .dat       (datBus.port)
    );

endmodule

`default_nettype wire

//--- bench/cpu8Tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu8Tb import cpu8Pkg::*; ();

    localparam logic [1:0] kAlu = 2'd0;
    localparam logic [1:0] kCarry = 2'd1;
    localparam logic [1:0] kMem = 2'd2;
    localparam logic [1:0] kJump = 2'd3;
    localparam int numRows = 16;
    localparam int numRandom = 6;
    localparam int waitLimit = 200;     // Cycles before a wait gives up
    localparam int haltWindow = 10;     // Quiet cycles checked after halt

    typedef struct packed {
        logic [1:0] kind;
        logic [3:0] op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] expVal;
        logic [3:0] expFlags;           // {0, N, Z, C}
    } rowT;

    logic        clk = 1'b0;
    logic        rstN;
    logic        run;
    logic        progWrEn;
    logic [7:0]  progAddr;
    logic [15:0] progData;
    logic [7:0]  outData;
    logic        outStrobe;
    logic        halted;

    rowT         rows [0:numRows-1];
    logic [15:0] prog [$];              // Program of the current row
    logic [7:0]  expQ [$];
    logic [7:0]  gotQ [$];              // outData at each strobe
    integer      seed;

    always #10 clk = ~clk;

    cpu8Top #(.dataAddrWidth(8)) cpu8Top_i (
        .clk(clk), .rstN(rstN), .run(run), .progWrEn(progWrEn),
        .progAddr(progAddr), .progData(progData),
        .outData(outData), .outStrobe(outStrobe), .halted(halted)
    );

    //******************************************************************
    // Encoders and reference ALU
    //******************************************************************
    function automatic logic [15:0] immInstr(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [7:0] imm);
        instrWordT w;
        w.immF.rd  = rd;
        w.immF.imm = imm;
        w.immF.op  = op;
        return w;
    endfunction

    function automatic logic [15:0] regInstr(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [3:0] rs);
        instrWordT w;
        w.regF = '{rd: rd, rs: rs, spare: 4'h0, op: op};
        return w;
    endfunction

    // {flags, result}, from the ALU rules
    function automatic logic [11:0] refAlu(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
        logic [8:0] wide;
        logic [7:0] res;
        logic       carry;
        wide  = {1'b0, a} + {1'b0, b};
        carry = 1'b0;
        case (op)
            opAdd: begin
                res   = wide[7:0];
                carry = wide[8];
            end
            opSub: begin
                res   = a - b;
                carry = (a < b);        // Borrow
            end
            opAnd:   res = a & b;
            opOr:    res = a | b;
            default: res = a ^ b;
        endcase
        return {1'b0, res[7], (res == 8'd0), carry, res};
    endfunction

    function automatic logic [3:0] pickAluOp(input logic [2:0] sel);
        case (sel % 3'd5)
            3'd0:    return opAdd;
            3'd1:    return opSub;
            3'd2:    return opAnd;
            3'd3:    return opOr;
            default: return opXor;
        endcase
    endfunction

    //******************************************************************
    // Error handling and check tasks
    //******************************************************************
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        assert (got == exp) else
            stopOnError($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic checkQuiet();
        @(negedge clk);
        assert (!outStrobe && !halted) else
            stopOnError("outStrobe or halted went high while run was low");
    endtask

    //******************************************************************
    // Program build, load and run
    //******************************************************************
    task automatic buildProgram(input rowT r);
        prog.delete();
        expQ.delete();
        case (r.kind)
            kAlu, kCarry: begin
                prog = '{immInstr(opLdi, 4'd1, r.a), immInstr(opLdi, 4'd2, r.b),
                         regInstr(r.op, 4'd1, 4'd2), regInstr(opOut, 4'd1, 4'd0),
                         regInstr(opOutf, 4'd0, 4'd0)};
                expQ = '{r.expVal, {4'h0, r.expFlags}};
                if (r.kind == kCarry) begin             // ADC sees C from the ADD
                    prog.push_back(immInstr(opLdi, 4'd3, 8'h10));
                    prog.push_back(immInstr(opLdi, 4'd4, 8'h20));
                    prog.push_back(regInstr(opAdc, 4'd3, 4'd4));
                    prog.push_back(regInstr(opOut, 4'd3, 4'd0));
                    expQ.push_back(8'h30 + {7'd0, r.expFlags[flagC]});
                end
            end
            kMem: begin
                // Two cells, value and its inverse at the next address
                prog = '{immInstr(opLdi, 4'd1, r.a), immInstr(opLdi, 4'd2, r.b),
                         immInstr(opLdi, 4'd3, ~r.a), immInstr(opLdi, 4'd4, r.b + 8'd1),
                         regInstr(opSt, 4'd1, 4'd2), regInstr(opSt, 4'd3, 4'd4),
                         regInstr(opLd, 4'd5, 4'd2), regInstr(opLd, 4'd6, 4'd4),
                         regInstr(opOut, 4'd5, 4'd0), regInstr(opOut, 4'd6, 4'd0)};
                expQ = '{r.expVal, ~r.a};
            end
            default: begin
                prog = '{immInstr(opLdi, 4'd1, r.a), immInstr(opLdi, 4'd2, r.b),
                         regInstr(r.op, 4'd1, 4'd2), immInstr(opJz, 4'd0, 8'd6),
                         immInstr(opLdi, 4'd3, 8'hAA), regInstr(opOut, 4'd3, 4'd0),
                         immInstr(opLdi, 4'd3, 8'h55), regInstr(opOut, 4'd3, 4'd0)};
                if (!r.expFlags[flagZ]) expQ.push_back(8'hAA);  // No jump taken
                expQ.push_back(r.expVal);
            end
        endcase
        prog.push_back(regInstr(opHalt, 4'd0, 4'd0));
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            progWrEn <= 1'b1;
            progAddr <= 8'(i);
            progData <= prog[i];
            checkQuiet();
        end
        @(posedge clk);
        progWrEn <= 1'b0;
    endtask

    task automatic runRow(input rowT r, input int idx);
        int cycles;
        buildProgram(r);
        loadProgram();
        @(posedge clk);
        run <= 1'b1;
        gotQ.delete();
        cycles = 0;
        do begin                                // Collect strobes until halt
            @(negedge clk);
            if (outStrobe) gotQ.push_back(outData);
            cycles++;
            if (!halted && cycles > waitLimit)
                stopOnError($sformatf("Timeout, halted never rose in row %0d", idx));
        end while (!halted);
        assert (gotQ.size() == expQ.size()) else
            stopOnError($sformatf("FAILED outStrobe count in row %0d: got 0x%h, expected 0x%h",
                                  idx, gotQ.size(), expQ.size()));
        for (int i = 0; i < expQ.size(); i++) checkValue("outData", gotQ[i], expQ[i]);
        repeat (haltWindow) begin
            @(negedge clk);
            assert (!outStrobe && halted) else
                stopOnError($sformatf("Core left halt or strobed after halt in row %0d", idx));
        end
        @(posedge clk);
        run <= 1'b0;                            // Back to idle
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (halted && cycles > waitLimit)
                stopOnError($sformatf("Timeout, halted stayed high in row %0d", idx));
        end while (halted);
    endtask

    //******************************************************************
    // Test table and main sequence
    //******************************************************************
    initial begin
        rowT         randRow;
        logic [31:0] rnd;
        logic [11:0] refRes;
        rstN <= 1'b0;
        run <= 1'b0;
        progWrEn <= 1'b0;
        progAddr <= 8'd0;
        progData <= 16'd0;
        seed = 5;
        // kind, op, a, b, expected value, expected flags {0, N, Z, C}
        rows[0]  = '{kAlu,   opAdd, 8'h12, 8'h34, 8'h46, 4'h0};
        rows[1]  = '{kAlu,   opAdd, 8'h80, 8'h80, 8'h00, 4'h3};  // Carry and zero
        rows[2]  = '{kAlu,   opAdd, 8'h70, 8'h20, 8'h90, 4'h4};
        rows[3]  = '{kAlu,   opSub, 8'h50, 8'h20, 8'h30, 4'h0};
        rows[4]  = '{kAlu,   opSub, 8'h20, 8'h50, 8'hD0, 4'h5};  // Borrow
        rows[5]  = '{kAlu,   opSub, 8'h33, 8'h33, 8'h00, 4'h2};
        rows[6]  = '{kAlu,   opAnd, 8'hF0, 8'h0F, 8'h00, 4'h2};
        rows[7]  = '{kAlu,   opAnd, 8'hCC, 8'hAA, 8'h88, 4'h4};
        rows[8]  = '{kAlu,   opOr,  8'h81, 8'h42, 8'hC3, 4'h4};
        rows[9]  = '{kAlu,   opXor, 8'h5A, 8'h5A, 8'h00, 4'h2};
        rows[10] = '{kAlu,   opXor, 8'hFF, 8'h0F, 8'hF0, 4'h4};
        rows[11] = '{kCarry, opAdd, 8'hFF, 8'h01, 8'h00, 4'h3};
        rows[12] = '{kMem,   opSt,  8'h5A, 8'h07, 8'h5A, 4'h0};  // a value, b address
        rows[13] = '{kMem,   opSt,  8'hC3, 8'h0E, 8'hC3, 4'h0};
        rows[14] = '{kJump,  opSub, 8'h42, 8'h42, 8'h55, 4'h2};  // Jump taken
        rows[15] = '{kJump,  opSub, 8'h42, 8'h41, 8'h55, 4'h0};
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        repeat (5) checkQuiet();
        for (int i = 0; i < numRows; i++) runRow(rows[i], i);
        for (int i = 0; i < numRandom; i++) begin
            rnd = $random(seed);
            randRow.kind = kAlu;
            randRow.op = pickAluOp(rnd[18:16]);
            randRow.a = rnd[7:0];
            randRow.b = rnd[15:8];
            refRes = refAlu(randRow.op, randRow.a, randRow.b);
            randRow.expVal = refRes[7:0];
            randRow.expFlags = refRes[11:8];
            runRow(randRow, numRows + i);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu8.f
hdl/cpu8Pkg.sv
hdl/cpu8If.sv
hdl/alu.sv
hdl/fetchUnit.sv
hdl/execCore.sv
hdl/dataPort.sv
hdl/cpu8Top.sv
bench/cpu8Tb.sv

//--- run.sh
#!/bin/bash
# Build the cpu8 testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f cpu8.f --top-module cpu8Tb -o cpu8Sim \
    && ./obj_dir/cpu8Sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
